// File: verilog/tama_pkg.sv
// tama core shared definitions
// bus word types, ROM load path constants and bridge register map

`default_nettype none

package tama_pkg;

  ////////////////////////////////////////////////////////////
  // bus and storage types

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;
  typedef logic [15:0] rom_word_t;
  typedef logic [12:0] rom_addr_t;
  typedef logic [11:0] rom_fetch_t;
  typedef logic [2:0] turbo_speed_t;
  typedef logic [1:0] lcd_mode_t;

  typedef enum logic [2:0] {
    reg_reset,
    reg_sound,
    reg_turbo,
    reg_lcd,
    reg_status,
    reg_rom,
    reg_none
  } reg_sel_e;

  // splitter sends the upper half first, the lower half waits one cycle
  typedef enum logic {
    split_idle,
    split_low_half
  } split_state_e;

  ////////////////////////////////////////////////////////////
  // load path and settings constants

  localparam int unsigned load_fifo_depth = 8;
  // top nibble of the bridge address selects the ROM region
  localparam logic [3:0] rom_region = 4'h1;
  localparam turbo_speed_t turbo_max = 3'd4;
  localparam int unsigned core_reset_cycles = 16;

  // counts up to the full depth, so one bit wider than a pointer
  typedef logic [$clog2(load_fifo_depth + 1)-1:0] load_count_t;
  typedef logic [$clog2(load_fifo_depth)-1:0] fifo_ptr_t;
  typedef logic [$clog2(core_reset_cycles + 1)-1:0] reset_count_t;

  // bridge register map
  localparam bridge_addr_t addr_reset = 32'h0;
  localparam bridge_addr_t addr_sound = 32'h10;
  localparam bridge_addr_t addr_turbo = 32'h100;
  localparam bridge_addr_t addr_lcd = 32'h200;
  localparam bridge_addr_t addr_status = 32'h300;

endpackage

`default_nettype wire

// File: verilog/rom_load_if.sv
// ROM load word link
// one address/word pair per valid cycle, credit returned by the sink

`default_nettype none

interface rom_load_if;
  import tama_pkg::*;

  logic valid;
  rom_addr_t addr;
  rom_word_t data;
  // one-cycle pulse, one slot freed downstream
  logic credit;

  modport source(output valid, output addr, output data, input credit);

  modport sink(input valid, input addr, input data, output credit);

endinterface

`default_nettype wire

// File: verilog/bridge_regs.sv
// bridge settings registers
// address decode, mute and LCD settings, timed core reset
// and the read-data mux back to the host

`default_nettype none

module bridge_regs (
  input wire clk_74a,
  input wire pll_core_locked,
  input wire tama_pkg::bridge_addr_t bridge_addr,
  input wire bridge_wr,
  input wire tama_pkg::bridge_data_t bridge_wr_data,
  input wire tama_pkg::turbo_speed_t turbo_speed,
  input wire load_overflow,
  output tama_pkg::bridge_data_t bridge_rd_data,
  output logic rom_wr,
  output logic turbo_set,
  output tama_pkg::turbo_speed_t turbo_value,
  output logic sound_mute,
  output tama_pkg::lcd_mode_t lcd_mode,
  output logic core_reset
);
  import tama_pkg::*;

  reg_sel_e reg_sel;
  reset_count_t reset_count;

  // shared by reads and writes
  always_comb begin
    if (bridge_addr[31:28] == rom_region) begin
      reg_sel = reg_rom;
    end else begin
      case (bridge_addr)
        addr_reset: reg_sel = reg_reset;
        addr_sound: reg_sel = reg_sound;
        addr_turbo: reg_sel = reg_turbo;
        addr_lcd: reg_sel = reg_lcd;
        addr_status: reg_sel = reg_status;
        default: reg_sel = reg_none;
      endcase
    end
  end

  assign rom_wr = bridge_wr && (reg_sel == reg_rom);
  assign turbo_set = bridge_wr && (reg_sel == reg_turbo);
  assign turbo_value = bridge_wr_data[$bits(turbo_speed_t)-1:0];
  assign core_reset = (reset_count != '0);

  ////////////////////////////////////////////////////////////
  // settings and reset delay

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      sound_mute <= 1'b0;
      lcd_mode <= '0;
      reset_count <= '0;
    end else begin
      // a new write restarts the delay
      if (bridge_wr && reg_sel == reg_reset) begin
        reset_count <= reset_count_t'(core_reset_cycles);
      end else if (reset_count != '0) begin
        reset_count <= reset_count - 1'b1;
      end
      if (bridge_wr && reg_sel == reg_sound) begin
        sound_mute <= bridge_wr_data[0];
      end
      if (bridge_wr && reg_sel == reg_lcd) begin
        lcd_mode <= bridge_wr_data[$bits(lcd_mode_t)-1:0];
      end
    end
  end

  // unmapped and write-only addresses read as zero
  always_comb begin
    bridge_rd_data = '0;
    case (reg_sel)
      reg_sound: bridge_rd_data = bridge_data_t'(sound_mute);
      reg_turbo: bridge_rd_data = bridge_data_t'(turbo_speed);
      reg_lcd: bridge_rd_data = bridge_data_t'(lcd_mode);
      reg_status: bridge_rd_data = bridge_data_t'(load_overflow);
      default: bridge_rd_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/rom_word_splitter.sv
// ROM word splitter
// turns one 32-bit bridge write into two byte-swapped 16-bit ROM words,
// sent upper half first, as long as the load FIFO has room for both

`default_nettype none

module rom_word_splitter (
  input wire clk_74a,
  input wire pll_core_locked,
  input wire rom_wr,
  input wire tama_pkg::bridge_addr_t bridge_addr,
  input wire tama_pkg::bridge_data_t bridge_wr_data,
  rom_load_if.source load_out,
  output logic load_overflow
);
  import tama_pkg::*;

  split_state_e state;
  load_count_t credit_count;
  load_count_t credit_avail;
  rom_addr_t word_addr;
  rom_addr_t low_addr;
  rom_word_t low_data;
  logic accept;

  // byte address to word address, upper bits dropped
  assign word_addr = bridge_addr[$bits(rom_addr_t):1];

  // the word on the link this cycle already spends a credit
  assign credit_avail = credit_count + load_count_t'(load_out.credit)
                        - load_count_t'(load_out.valid);

  assign accept = rom_wr && (state == split_idle) && (credit_avail >= load_count_t'(2));

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state <= split_idle;
      credit_count <= load_count_t'(load_fifo_depth);
      load_out.valid <= 1'b0;
      load_overflow <= 1'b0;
    end else begin
      credit_count <= credit_count + load_count_t'(load_out.credit)
                      - load_count_t'(load_out.valid);
      if (accept) begin
        state <= split_low_half;
        load_out.valid <= 1'b1;
      end else if (state == split_low_half) begin
        state <= split_idle;
        load_out.valid <= 1'b1;
      end else begin
        load_out.valid <= 1'b0;
      end
      // sticky until reset
      if (rom_wr && !accept) begin
        load_overflow <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // payload, lower half parked while the upper half goes out

  always_ff @(posedge clk_74a) begin
    if (accept) begin
      load_out.addr <= word_addr;
      load_out.data <= {bridge_wr_data[23:16], bridge_wr_data[31:24]};
      low_addr <= word_addr + 1'b1;
      low_data <= {bridge_wr_data[7:0], bridge_wr_data[15:8]};
    end else if (state == split_low_half) begin
      load_out.addr <= low_addr;
      load_out.data <= low_data;
    end
  end

endmodule

`default_nettype wire

// File: verilog/rom_load_fifo.sv
// ROM load FIFO
// eight-entry circular buffer of address/word pairs between the
// splitter and the ROM store, each pop is handed back upstream as a credit

`default_nettype none

module rom_load_fifo (
  input wire clk_74a,
  input wire pll_core_locked,
  rom_load_if.sink load_in,
  rom_load_if.source load_out
);
  import tama_pkg::*;

  rom_addr_t addr_mem[load_fifo_depth];
  rom_word_t data_mem[load_fifo_depth];
  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  load_count_t fill;
  logic pop;

  // upstream never pushes without a credit, so no full check here
  assign pop = load_out.credit && (fill != '0);
  assign load_in.credit = pop;

  // head entry
  assign load_out.valid = (fill != '0);
  assign load_out.addr = addr_mem[rd_ptr];
  assign load_out.data = data_mem[rd_ptr];

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill <= '0;
    end else begin
      if (load_in.valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fill <= fill + load_count_t'(load_in.valid) - load_count_t'(pop);
    end
  end

  always_ff @(posedge clk_74a) begin
    if (load_in.valid) begin
      addr_mem[wr_ptr] <= load_in.addr;
      data_mem[wr_ptr] <= load_in.data;
    end
  end

endmodule

`default_nettype wire

// File: verilog/rom_store.sv
// program ROM, 8192 x 16, single port
// instruction fetch owns the port, load words go in on idle cycles

`default_nettype none

module rom_store (
  input wire clk_74a,
  rom_load_if.sink load_in,
  input wire rom_fetch,
  input wire tama_pkg::rom_addr_t rom_addr,
  output tama_pkg::rom_fetch_t rom_data
);
  import tama_pkg::*;

  rom_word_t mem[2 ** $bits(rom_addr_t)];
  logic load_write;

  // credit pulse marks the head word as written
  assign load_write = load_in.valid && !rom_fetch;
  assign load_in.credit = load_write;

  always_ff @(posedge clk_74a) begin
    if (rom_fetch) begin
      // instructions are 12 bits, top nibble ignored
      rom_data <= mem[rom_addr][$bits(rom_fetch_t)-1:0];
    end else if (load_write) begin
      mem[load_in.addr] <= load_in.data;
    end
  end

endmodule

`default_nettype wire

// File: verilog/turbo_control.sv
// turbo speed control
// L1/R1 trigger edges step the speed, a bridge write sets it directly

`default_nettype none

module turbo_control (
  input wire clk_74a,
  input wire pll_core_locked,
  input wire trig_l1,
  input wire trig_r1,
  input wire turbo_set,
  input wire tama_pkg::turbo_speed_t turbo_value,
  output tama_pkg::turbo_speed_t turbo_speed
);
  import tama_pkg::*;

  logic l1_prev;
  logic r1_prev;
  logic l1_rise;
  logic r1_rise;

  assign l1_rise = trig_l1 && !l1_prev;
  assign r1_rise = trig_r1 && !r1_prev;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      l1_prev <= 1'b0;
      r1_prev <= 1'b0;
      turbo_speed <= '0;
    end else begin
      l1_prev <= trig_l1;
      r1_prev <= trig_r1;
      // host write wins over buttons
      if (turbo_set) begin
        turbo_speed <= (turbo_value > turbo_max) ? turbo_max : turbo_value;
      end else if (r1_rise && !l1_rise && turbo_speed < turbo_max) begin
        turbo_speed <= turbo_speed + 1'b1;
      end else if (l1_rise && !r1_rise && turbo_speed != '0) begin
        turbo_speed <= turbo_speed - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/core_top.sv
// tama core top level
// bridge settings, ROM load path into program ROM, and turbo control

`default_nettype none

module core_top (
  input wire clk_74a,
  input wire pll_core_locked,
  input wire tama_pkg::bridge_addr_t bridge_addr,
  // kept for bus compatibility, reads are combinational
  input wire bridge_rd,
  input wire bridge_wr,
  input wire tama_pkg::bridge_data_t bridge_wr_data,
  output tama_pkg::bridge_data_t bridge_rd_data,
  input wire [15:0] cont1_key,
  input wire rom_fetch,
  input wire tama_pkg::rom_addr_t rom_addr,
  output tama_pkg::rom_fetch_t rom_data,
  output tama_pkg::turbo_speed_t turbo_speed,
  output logic sound_mute,
  output tama_pkg::lcd_mode_t lcd_mode,
  output logic core_reset
);
  import tama_pkg::*;

  logic rom_wr;
  logic turbo_set;
  turbo_speed_t turbo_value;
  logic load_overflow;

  rom_load_if split_link ();
  rom_load_if store_link ();

  ////////////////////////////////////////////////////////////
  // host settings

  bridge_regs bridge_regs_inst (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .turbo_speed    (turbo_speed),
    .load_overflow  (load_overflow),
    .bridge_rd_data (bridge_rd_data),
    .rom_wr         (rom_wr),
    .turbo_set      (turbo_set),
    .turbo_value    (turbo_value),
    .sound_mute     (sound_mute),
    .lcd_mode       (lcd_mode),
    .core_reset     (core_reset)
  );

  // key bit 8 is L1, bit 9 is R1
  turbo_control turbo_control_inst (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .trig_l1        (cont1_key[8]),
    .trig_r1        (cont1_key[9]),
    .turbo_set      (turbo_set),
    .turbo_value    (turbo_value),
    .turbo_speed    (turbo_speed)
  );

  ////////////////////////////////////////////////////////////
  // ROM load path

  rom_word_splitter rom_word_splitter_inst (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .rom_wr         (rom_wr),
    .bridge_addr    (bridge_addr),
    .bridge_wr_data (bridge_wr_data),
    .load_out       (split_link.source),
    .load_overflow  (load_overflow)
  );

  rom_load_fifo rom_load_fifo_inst (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .load_in        (split_link.sink),
    .load_out       (store_link.source)
  );

  rom_store rom_store_inst (
    .clk_74a  (clk_74a),
    .load_in  (store_link.sink),
    .rom_fetch(rom_fetch),
    .rom_addr (rom_addr),
    .rom_data (rom_data)
  );

endmodule

`default_nettype wire

// File: test/tb_checks.svh
// testbench compare tasks
// one typed compare per kind of DUT result, the first mismatch ends the run

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int unsigned checks_done = 0;

task automatic abort_run(input string why);
  $display("%s", why);
  $display("TEST RESULT: FAIL");
  $fatal(1, "simulation stopped at the first error");
endtask

// 12-bit instruction from the ROM fetch port
task automatic check_rom(input string name, input rom_fetch_t got, input rom_fetch_t expected);
  checks_done++;
  if (got !== expected) begin
    abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, expected));
  end
endtask

// bridge read data and register readouts
task automatic check_reg(input string name, input bridge_data_t got,
                         input bridge_data_t expected);
  checks_done++;
  if (got !== expected) begin
    abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, expected));
  end
endtask

task automatic check_turbo(input string name, input turbo_speed_t got,
                           input turbo_speed_t expected);
  checks_done++;
  if (got !== expected) begin
    abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, expected));
  end
endtask

// single-bit outputs such as core_reset and sound_mute
task automatic check_flag(input string name, input logic got, input logic expected);
  checks_done++;
  if (got !== expected) begin
    abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, expected));
  end
endtask

`endif

// File: test/tb_core.sv
// tama core testbench
// replays bridge, ROM fetch and key commands from the test data file
// and compares register reads, fetched words and reset timing

`default_nettype none

module tb_core;
  import tama_pkg::*;

  `include "tb_checks.svh"

  localparam string data_path = "test/core_testdata.txt";

  logic clk_74a;
  logic pll_core_locked;
  bridge_addr_t bridge_addr;
  logic bridge_rd;
  logic bridge_wr;
  bridge_data_t bridge_wr_data;
  bridge_data_t bridge_rd_data;
  logic [15:0] cont1_key;
  logic rom_fetch;
  rom_addr_t rom_addr;
  rom_fetch_t rom_data;
  turbo_speed_t turbo_speed;
  logic sound_mute;
  lcd_mode_t lcd_mode;
  logic core_reset;

  // fetch level to return to after a single fetch
  logic fetch_hold;
  integer seed = 32'hdffd86ca;
  int unsigned line_count;
  int unsigned cycle_limit;
  int unsigned cycle_count;

  core_top core_top_inst (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_rd      (bridge_rd),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd_data (bridge_rd_data),
    .cont1_key      (cont1_key),
    .rom_fetch      (rom_fetch),
    .rom_addr       (rom_addr),
    .rom_data       (rom_data),
    .turbo_speed    (turbo_speed),
    .sound_mute     (sound_mute),
    .lcd_mode       (lcd_mode),
    .core_reset     (core_reset)
  );

  initial begin
    clk_74a = 1'b0;
    forever #2 clk_74a = ~clk_74a;
  end

  // watchdog
  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk_74a);
      cycle_count++;
      if (cycle_count > cycle_limit) begin
        abort_run($sformatf("timeout: test did not finish within %0d cycles", cycle_limit));
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // bus and port tasks

  task automatic bus_write(input bridge_addr_t addr, input bridge_data_t data);
    int unsigned i;
    @(posedge clk_74a);
    bridge_addr <= addr;
    bridge_wr_data <= data;
    bridge_wr <= 1'b1;
    @(negedge clk_74a);
    if (addr == addr_reset) begin
      check_flag("core_reset", core_reset, 1'b0);
    end
    @(posedge clk_74a);
    bridge_wr <= 1'b0;
    if (addr == addr_reset) begin
      // high from the cycle after the write edge, for the whole delay
      for (i = 0; i < core_reset_cycles; i++) begin
        @(negedge clk_74a);
        check_flag("core_reset", core_reset, 1'b1);
      end
      @(negedge clk_74a);
      check_flag("core_reset", core_reset, 1'b0);
    end
  endtask

  task automatic bus_read(input bridge_addr_t addr, input bridge_data_t expected);
    @(posedge clk_74a);
    bridge_addr <= addr;
    bridge_rd <= 1'b1;
    @(negedge clk_74a);
    check_reg("bridge_rd_data", bridge_rd_data, expected);
    // register readouts mirrored on the output ports
    if (addr == addr_turbo) begin
      check_turbo("turbo_speed", turbo_speed, turbo_speed_t'(expected));
    end
    if (addr == addr_sound) begin
      check_flag("sound_mute", sound_mute, expected[0]);
    end
    if (addr == addr_lcd) begin
      check_reg("lcd_mode", bridge_data_t'(lcd_mode), expected);
    end
    @(posedge clk_74a);
    bridge_rd <= 1'b0;
  endtask

  task automatic fetch_word(input rom_addr_t addr, input rom_fetch_t expected);
    @(posedge clk_74a);
    rom_fetch <= 1'b1;
    rom_addr <= addr;
    @(posedge clk_74a);
    rom_fetch <= fetch_hold;
    @(negedge clk_74a);
    check_rom("rom_data", rom_data, expected);
  endtask

  // one press and release per step, so every press is a rising edge
  task automatic press_keys(input logic [15:0] mask, input int unsigned presses);
    repeat (presses) begin
      @(posedge clk_74a);
      cont1_key <= mask;
      @(posedge clk_74a);
      cont1_key <= '0;
      @(posedge clk_74a);
    end
  endtask

  task automatic idle_gap();
    int unsigned cycles;
    cycles = 2 + ($random(seed) & 3);
    repeat (cycles) @(posedge clk_74a);
  endtask

  ////////////////////////////////////////////////////////////
  // data file

  task automatic count_lines();
    integer fd;
    integer r;
    reg [8*256-1:0] line;
    line_count = 0;
    fd = $fopen(data_path, "r");
    if (fd == 0) begin
      abort_run("cannot open the test data file");
    end
    while (!$feof(fd)) begin
      r = $fgets(line, fd);
      if (r != 0) begin
        line_count++;
      end
    end
    $fclose(fd);
  endtask

  task automatic run_command(input reg [8*16-1:0] op, input bridge_data_t arg_a,
                             input bridge_data_t arg_b);
    if (op == "write") begin
      bus_write(arg_a, arg_b);
    end else if (op == "read_expect") begin
      bus_read(arg_a, arg_b);
    end else if (op == "fetch_expect") begin
      fetch_word(rom_addr_t'(arg_a), rom_fetch_t'(arg_b));
    end else if (op == "hold_fetch") begin
      @(posedge clk_74a);
      fetch_hold = arg_b[0];
      rom_fetch <= arg_b[0];
    end else if (op == "key") begin
      press_keys(arg_a[15:0], arg_b);
    end else if (op == "wait") begin
      repeat (arg_b) @(posedge clk_74a);
    end else begin
      abort_run($sformatf("unknown command %0s in the test data file", op));
    end
  endtask

  task automatic run_file();
    integer fd;
    integer r;
    reg [8*16-1:0] op;
    reg [8*256-1:0] line;
    bridge_data_t arg_a;
    bridge_data_t arg_b;
    fd = $fopen(data_path, "r");
    if (fd == 0) begin
      abort_run("cannot open the test data file");
    end
    op = '0;
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op == "#") begin
        r = $fgets(line, fd);
      end else begin
        r = $fscanf(fd, "%h %h", arg_a, arg_b);
        if (r != 2) begin
          abort_run($sformatf("missing operands after command %0s", op));
        end
        run_command(op, arg_a, arg_b);
        idle_gap();
      end
      op = '0;
    end
    $fclose(fd);
  endtask

  initial begin
    pll_core_locked <= 1'b0;
    bridge_addr <= '0;
    bridge_rd <= 1'b0;
    bridge_wr <= 1'b0;
    bridge_wr_data <= '0;
    cont1_key <= '0;
    rom_fetch <= 1'b0;
    rom_addr <= '0;
    fetch_hold = 1'b0;
    cycle_limit = 200;
    count_lines();
    cycle_limit = 20 * line_count + 200;
    repeat (5) @(posedge clk_74a);
    pll_core_locked <= 1'b1;
    @(negedge clk_74a);
    check_flag("core_reset", core_reset, 1'b0);
    check_flag("sound_mute", sound_mute, 1'b0);
    check_turbo("turbo_speed", turbo_speed, '0);
    run_file();
    if (checks_done > 0) begin
      $display("checks run: %0d", checks_done);
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      abort_run("no checks were run from the test data file");
    end
  end

endmodule

`default_nettype wire

// File: test/core_testdata.txt
# op           addr/mask  value/count  (all operands in hex)
# write, read_expect, fetch_expect, hold_fetch, key, wait
write        00000010 00000001
read_expect  00000010 00000001
write        00000200 00000002
read_expect  00000200 00000002
write        00000000 00000000
key          00000200 00000005
read_expect  00000100 00000004
key          00000100 00000006
read_expect  00000100 00000000
write        00000100 00000007
read_expect  00000100 00000004
write        10000000 12345678
write        10000004 a1b2c3d4
write        10003ffc cafef00d
wait         00000000 0000000c
fetch_expect 00000000 00000412
fetch_expect 00000001 00000856
fetch_expect 00000002 000002a1
fetch_expect 00000003 000004c3
fetch_expect 00001ffe 00000eca
fetch_expect 00001fff 00000df0
hold_fetch   00000000 00000001
write        10000100 11223344
write        10000104 55667788
write        10000108 99aabbcc
hold_fetch   00000000 00000000
wait         00000000 0000000c
read_expect  00000300 00000000
fetch_expect 00000080 00000211
fetch_expect 00000081 00000433
fetch_expect 00000082 00000655
fetch_expect 00000083 00000877
fetch_expect 00000084 00000a99
fetch_expect 00000085 00000cbb
write        10000210 c0ffee11
wait         00000000 0000000c
hold_fetch   00000000 00000001
write        10000200 01020304
write        10000204 05060708
write        10000208 090a0b0c
write        1000020c 0d0e0f10
write        10000210 11121314
read_expect  00000300 00000001
hold_fetch   00000000 00000000
wait         00000000 0000000c
fetch_expect 00000100 00000201
fetch_expect 00000107 0000000f
fetch_expect 00000108 00000fc0
fetch_expect 00000109 000001ee

// File: tb.f
+incdir+test
verilog/tama_pkg.sv
verilog/rom_load_if.sv
verilog/bridge_regs.sv
verilog/rom_word_splitter.sv
verilog/rom_load_fifo.sv
verilog/rom_store.sv
verilog/turbo_control.sv
verilog/core_top.sv
test/tb_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the tb_core simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_core -f tb.f
./obj_dir/Vtb_core | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
